// File: source/soc_pkg.sv
// fixed address map; rom base must be aligned to the rom size, only okay and decerr are used
`default_nettype none

package soc_pkg;

	// widths with a meaning
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  resp_t;
	typedef logic [63:0] mtime_t;

	// axi read responses in use
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// clint mtime, split into two 32-bit words
	localparam addr_t CLINT_MTIME_LO = 32'hA000_0048;
	localparam addr_t CLINT_MTIME_HI = 32'hA000_004C;

	// boot rom window
	localparam addr_t ROM_BASE  = 32'h8000_0000;
	localparam int    ROM_WORDS = 16;
	localparam int    ROM_AW    = $clog2(ROM_WORDS);

	// read machine shared by the slaves
	typedef enum logic {
		IDLE,
		RESP
	} slave_state_t;

endpackage

`default_nettype wire

// File: source/axi_lite_rd_if.sv
// AXI-Lite read channels only; no burst, prot or id signals, one read in flight per link
`default_nettype none

interface axi_lite_rd_if
	import soc_pkg::*;
();

	// read address channel
	addr_t araddr;
	logic  arvalid;
	logic  arready;

	// read data channel
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	// decoder side
	modport mst (
		output araddr,
		output arvalid,
		input  arready,
		input  rdata,
		input  rresp,
		input  rvalid,
		output rready
	);

	// timer and rom side
	modport slv (
		input  araddr,
		input  arvalid,
		output arready,
		output rdata,
		output rresp,
		output rvalid,
		input  rready
	);

endinterface

`default_nettype wire

// File: source/clint_timer.sv
// read-only mtime; any address other than the low word returns the high-word shadow
`default_nettype none

module clint_timer
	import soc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	axi_lite_rd_if.slv bus
);

	mtime_t       mtime;
	data_t        hi_shadow;
	data_t        rdata_q;
	logic         arready_q;
	slave_state_t state_q;
	slave_state_t state_d;
	logic         ar_hs;
	logic         r_hs;
	logic         lo_sel;

	assign ar_hs  = bus.arvalid && bus.arready;
	assign r_hs   = bus.rvalid && bus.rready;
	assign lo_sel = (bus.araddr == CLINT_MTIME_LO);

	// free-running timer
	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + mtime_t'(1);
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (ar_hs) begin
					state_d = RESP;
				end
			end
			RESP: begin
				if (r_hs) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	// arready drops with the AR handshake, returns after the R handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= IDLE;
			arready_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			arready_q <= (state_d == IDLE);
		end
	end

	// low read snapshots the high half so a lo/hi pair is coherent
	always_ff @(posedge clk) begin
		if (rst) begin
			hi_shadow <= '0;
		end else if (ar_hs && lo_sel) begin
			hi_shadow <= mtime[63:32];
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= lo_sel ? mtime[31:0] : hi_shadow;
		end
	end

	assign bus.arready = arready_q;
	assign bus.rvalid  = (state_q == RESP);
	assign bus.rdata   = rdata_q;
	assign bus.rresp   = RESP_OKAY;

	// one read at a time
	a_no_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
		!(bus.arready && bus.rvalid))
		else $error("clint accepts a read while a response is pending");

endmodule

`default_nettype wire

// File: source/boot_rom.sv
// contents come from source/boot_rom.hex, resolved from the run directory; only bits 5:2 index
`default_nettype none

module boot_rom
	import soc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	axi_lite_rd_if.slv bus
);

	data_t             rom [ROM_WORDS];
	data_t             rdata_q;
	logic [ROM_AW-1:0] word_idx;
	logic              arready_q;
	slave_state_t      state_q;
	slave_state_t      state_d;
	logic              ar_hs;
	logic              r_hs;

	initial begin
		$readmemh("source/boot_rom.hex", rom);
	end

	assign ar_hs    = bus.arvalid && bus.arready;
	assign r_hs     = bus.rvalid && bus.rready;
	assign word_idx = bus.araddr[ROM_AW+1:2];

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (ar_hs) begin
					state_d = RESP;
				end
			end
			RESP: begin
				if (r_hs) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= IDLE;
			arready_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			arready_q <= (state_d == IDLE);
		end
	end

	// word captured at the AR handshake
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= rom[word_idx];
		end
	end

	assign bus.arready = arready_q;
	assign bus.rvalid  = (state_q == RESP);
	assign bus.rdata   = rdata_q;
	assign bus.rresp   = RESP_OKAY;

	a_rdata_held: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata))
		else $error("rom response changed under back-pressure");

endmodule

`default_nettype wire

// File: source/rd_decoder.sv
// single read in flight across all targets; unmapped reads get decerr with zero data
`default_nettype none

module rd_decoder
	import soc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  addr_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	output data_t      rdata,
	output resp_t      rresp,
	output logic       rvalid,
	input  logic       rready,
	axi_lite_rd_if.mst clint,
	axi_lite_rd_if.mst rom
);

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_CLINT,
		TGT_ROM,
		TGT_ERR
	} target_t;

	target_t sel;
	target_t tgt_q;
	target_t tgt_d;
	logic    ready_q;
	logic    clint_hit;
	logic    rom_hit;
	logic    ar_hs;
	logic    r_hs;

	// address map
	assign clint_hit = (araddr == CLINT_MTIME_LO) || (araddr == CLINT_MTIME_HI);
	assign rom_hit   = (araddr[31:ROM_AW+2] == ROM_BASE[31:ROM_AW+2])
		&& (araddr[1:0] == 2'b00);

	always_comb begin
		if (clint_hit) begin
			sel = TGT_CLINT;
		end else if (rom_hit) begin
			sel = TGT_ROM;
		end else begin
			sel = TGT_ERR;
		end
	end

	// AR forwarded only while nothing is in flight
	assign clint.araddr  = araddr;
	assign clint.arvalid = arvalid && ready_q && (sel == TGT_CLINT);
	assign rom.araddr    = araddr;
	assign rom.arvalid   = arvalid && ready_q && (sel == TGT_ROM);

	always_comb begin
		case (sel)
			TGT_CLINT: arready = ready_q && clint.arready;
			TGT_ROM:   arready = ready_q && rom.arready;
			default:   arready = ready_q;
		endcase
	end

	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready;

	always_comb begin
		tgt_d = tgt_q;
		if (ar_hs) begin
			tgt_d = sel;
		end else if (r_hs) begin
			tgt_d = TGT_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tgt_q   <= TGT_NONE;
			ready_q <= 1'b0;
		end else begin
			tgt_q   <= tgt_d;
			ready_q <= (tgt_d == TGT_NONE);
		end
	end

	// R channel from the recorded target only
	assign clint.rready = rready && (tgt_q == TGT_CLINT);
	assign rom.rready   = rready && (tgt_q == TGT_ROM);

	always_comb begin
		rvalid = 1'b0;
		rdata  = '0;
		rresp  = RESP_OKAY;
		case (tgt_q)
			TGT_CLINT: begin
				rvalid = clint.rvalid;
				rdata  = clint.rdata;
				rresp  = clint.rresp;
			end
			TGT_ROM: begin
				rvalid = rom.rvalid;
				rdata  = rom.rdata;
				rresp  = rom.rresp;
			end
			// decoder answers by itself
			TGT_ERR: begin
				rvalid = 1'b1;
				rresp  = RESP_DECERR;
			end
			default: ;
		endcase
	end

	a_rvalid_held: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before the R handshake");

endmodule

`default_nettype wire

// File: source/soc_rd_top.sv
// AXI-Lite read port only; one cycle from AR handshake to rvalid for every address
`default_nettype none

module soc_rd_top
	import soc_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output data_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready
);

	// decoder to slave links
	axi_lite_rd_if clint_bus ();
	axi_lite_rd_if rom_bus ();

	rd_decoder u_dec (
		.clk     (clk),
		.rst     (rst),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.clint   (clint_bus),
		.rom     (rom_bus)
	);

	clint_timer u_clint (
		.clk (clk),
		.rst (rst),
		.bus (clint_bus)
	);

	boot_rom u_rom (
		.clk (clk),
		.rst (rst),
		.bus (rom_bus)
	);

endmodule

`default_nettype wire

// File: dv/tb_soc_rd.sv
// drives the top-level read port only; expected rom words come from source/boot_rom.hex
`default_nettype none

module tb_soc_rd
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS = 6;

	logic  clk;
	logic  rst;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	data_t       rom_ref [ROM_WORDS];
	int unsigned edge_count = 0;
	int unsigned last_ar_edge = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_done = 0;

	soc_rd_top dut0 (
		.clk     (clk),
		.rst     (rst),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reference for mtime deltas
	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	initial begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 200);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_done++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// one read, holding rready low for stall cycles once rvalid is up
	task automatic read_word(input addr_t addr, input int stall, output data_t data,
		output resp_t resp, output int lat);
		int    tries;
		int    held;
		logic  seen;
		data_t first_data;
		resp_t first_resp;
		data       = '0;
		resp       = '0;
		lat        = 0;
		tries      = 0;
		held       = 0;
		seen       = 1'b0;
		first_data = '0;
		first_resp = '0;
		araddr     = addr;
		arvalid    = 1'b1;
		rready     = 1'b0;
		@(negedge clk);
		while (!arready) begin
			tries++;
			if (tries > 16) begin
				note_error($sformatf("read of address %h was never accepted", addr));
				arvalid = 1'b0;
				return;
			end
			@(negedge clk);
		end
		// no response may show up before the address is taken
		check_eq("rvalid before handshake", 64'(rvalid), 64'(1'b0));
		// AR handshake on this edge
		@(posedge clk);
		#2;
		last_ar_edge = edge_count;
		arvalid      = 1'b0;
		araddr       = '0;
		rready       = (stall == 0);
		while (1'b1) begin
			@(negedge clk);
			if (!seen) begin
				lat++;
			end
			if (rvalid) begin
				if (!seen) begin
					seen       = 1'b1;
					first_data = rdata;
					first_resp = rresp;
				end else begin
					check_eq("rdata held", 64'(rdata), 64'(first_data));
					check_eq("rresp held", 64'(rresp), 64'(first_resp));
				end
				check_eq("arready while busy", 64'(arready), 64'(1'b0));
				if (rready) begin
					break;
				end
				held++;
			end else if (seen) begin
				note_error("rvalid dropped before the read data was taken");
				rready = 1'b0;
				return;
			end else if (lat >= 16) begin
				note_error($sformatf("no response for the read of address %h", addr));
				return;
			end
			@(posedge clk);
			#2;
			if (seen && held >= stall) begin
				rready = 1'b1;
			end
		end
		@(posedge clk);
		#2;
		rready = 1'b0;
		data   = first_data;
		resp   = first_resp;
	endtask

	task automatic check_reset_state();
		int errs_before;
		errs_before = errors;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_eq("arready in reset", 64'(arready), 64'(1'b0));
		check_eq("rvalid in reset", 64'(rvalid), 64'(1'b0));
		@(posedge clk);
		#2;
		rst = 1'b0;
		// first edge that sees rst low
		@(posedge clk);
		@(negedge clk);
		check_eq("arready after reset", 64'(arready), 64'(1'b1));
		check_eq("rvalid after reset", 64'(rvalid), 64'(1'b0));
		@(posedge clk);
		#2;
		end_test("reset state", errs_before);
	endtask

	task automatic read_rom_words();
		int    errs_before;
		data_t d;
		resp_t r;
		int    lat;
		errs_before = errors;
		for (int i = 0; i < ROM_WORDS; i++) begin
			read_word(ROM_BASE + addr_t'(4 * i), 0, d, r, lat);
			check_eq($sformatf("rom[%0d]", i), 64'(d), 64'(rom_ref[i]));
			check_eq("rresp", 64'(r), 64'(RESP_OKAY));
			check_eq("rvalid latency", 64'(lat), 64'(1));
		end
		end_test("rom words", errs_before);
	endtask

	task automatic compare_mtime_deltas();
		int          errs_before;
		data_t       lo_first;
		data_t       lo_second;
		int unsigned edge_first;
		resp_t       r;
		int          lat;
		errs_before = errors;
		for (int gap = 0; gap < 3; gap++) begin
			read_word(CLINT_MTIME_LO, 0, lo_first, r, lat);
			edge_first = last_ar_edge;
			idle(gap * 6 + 1);
			read_word(CLINT_MTIME_LO, gap, lo_second, r, lat);
			check_eq("mtime_lo delta", 64'(lo_second - lo_first),
				64'(last_ar_edge - edge_first));
			check_eq("rresp", 64'(r), 64'(RESP_OKAY));
		end
		end_test("mtime delta", errs_before);
	endtask

	task automatic read_mtime_pairs();
		int     errs_before;
		data_t  lo;
		data_t  hi;
		mtime_t now;
		mtime_t prev;
		resp_t  r;
		int     lat;
		errs_before = errors;
		prev        = '0;
		for (int p = 0; p < 3; p++) begin
			read_word(CLINT_MTIME_LO, 0, lo, r, lat);
			read_word(CLINT_MTIME_HI, p, hi, r, lat);
			check_eq("rresp", 64'(r), 64'(RESP_OKAY));
			// run is far shorter than 2**32 cycles
			check_eq("mtime_hi shadow", 64'(hi), 64'(0));
			now = {hi, lo};
			if (p > 0 && now <= prev) begin
				note_error($sformatf("mtime did not increase, %0h after %0h", now, prev));
			end
			prev = now;
			idle(3);
		end
		end_test("mtime pair", errs_before);
	endtask

	task automatic probe_unmapped();
		int    errs_before;
		addr_t bad_addr [6];
		data_t d;
		resp_t r;
		int    lat;
		errs_before = errors;
		bad_addr[0] = 32'h0000_0000;
		bad_addr[1] = 32'hA000_0044;
		bad_addr[2] = 32'hA000_0049;
		bad_addr[3] = ROM_BASE + 32'h2;
		bad_addr[4] = ROM_BASE + addr_t'(4 * ROM_WORDS);
		bad_addr[5] = 32'hFFFF_FFFC;
		for (int i = 0; i < 6; i++) begin
			read_word(bad_addr[i], 0, d, r, lat);
			check_eq($sformatf("rresp at %h", bad_addr[i]), 64'(r), 64'(RESP_DECERR));
			check_eq($sformatf("rdata at %h", bad_addr[i]), 64'(d), 64'(0));
			check_eq("rvalid latency", 64'(lat), 64'(1));
		end
		end_test("decode error", errs_before);
	endtask

	task automatic stall_responses();
		int    errs_before;
		int    stall;
		int    idx;
		data_t d;
		resp_t r;
		int    lat;
		errs_before = errors;
		for (int k = 0; k < 8; k++) begin
			stall = int'($urandom_range(7, 0));
			idx   = (k * 5 + 3) % ROM_WORDS;
			read_word(ROM_BASE + addr_t'(4 * idx), stall, d, r, lat);
			check_eq($sformatf("rom[%0d] stalled", idx), 64'(d), 64'(rom_ref[idx]));
			check_eq("rresp", 64'(r), 64'(RESP_OKAY));
		end
		stall = int'($urandom_range(7, 0));
		read_word(32'h0000_1000, stall, d, r, lat);
		check_eq("rresp stalled decerr", 64'(r), 64'(RESP_DECERR));
		check_eq("rdata stalled decerr", 64'(d), 64'(0));
		stall = int'($urandom_range(7, 0));
		read_word(CLINT_MTIME_HI, stall, d, r, lat);
		check_eq("mtime_hi stalled", 64'(d), 64'(0));
		// plain read right after the stalled ones
		read_word(ROM_BASE + addr_t'(4 * (ROM_WORDS - 1)), 0, d, r, lat);
		check_eq("rom last word", 64'(d), 64'(rom_ref[ROM_WORDS - 1]));
		end_test("back-pressure", errs_before);
	endtask

	initial begin
		void'($urandom(40));
		rst     = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		$readmemh("source/boot_rom.hex", rom_ref);
		check_reset_state();
		read_rom_words();
		compare_mtime_deltas();
		read_mtime_pairs();
		probe_unmapped();
		stall_responses();
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/boot_rom.hex
// one 32-bit word per line, word 0 sits at the rom base address
00000297
02028593
f1402573
0182a283
00028067
10500073
ffdff06f
00000013
80000000
8badf00d
deadbeef
0a0b0c0d
12345678
9abcdef0
55aa55aa
c001d00d

// File: build.f
source/soc_pkg.sv
source/axi_lite_rd_if.sv
source/clint_timer.sv
source/boot_rom.sv
source/rd_decoder.sv
source/soc_rd_top.sv
dv/tb_soc_rd.sv

// File: Makefile
TOP := tb_soc_rd
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
